// File: hdl/gat_pkg.sv
package gat_pkg;

  ////////////////////
  // Accelerator geometry
  ////////////////////
  localparam int GAT_NUM_SPARSE  = 12;  // Sparse items per node group
  localparam int GAT_NUM_LANES   = 16;  // Sparse PE lanes
  localparam int GAT_LANE_W      = 12;
  localparam int GAT_LANE_SEL_W  = 4;

  ////////////////////
  // Memory ports
  ////////////////////
  localparam int GAT_WH_ADDR_W   = 14;  // Weight memory port A
  localparam int GAT_FEAT_ADDR_W = 16;  // Feature memory port A

  typedef logic [GAT_LANE_W-1:0]      lane_t;
  typedef lane_t [GAT_NUM_LANES-1:0]  sppe_bus_t;
  typedef logic [GAT_LANE_SEL_W-1:0]  lane_sel_t;

  typedef logic [GAT_WH_ADDR_W-1:0]   wh_addr_t;
  typedef logic [GAT_FEAT_ADDR_W-1:0] feat_addr_t;

  // Feature writes at or above this land in the high region
  localparam feat_addr_t FEAT_HIGH_ADDR = 16'd43328;

endpackage

// File: hdl/dbg_pkg.sv
package dbg_pkg;

  ////////////////////
  // Register map
  ////////////////////
  localparam int REG_ADDR_W = 3;
  localparam int REG_DATA_W = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_DATA_W-1:0] reg_data_t;

  localparam reg_addr_t REG_ID        = 3'd0;  // RO
  localparam reg_addr_t REG_STICKY    = 3'd1;  // W1C
  localparam reg_addr_t REG_CAP_ADDR0 = 3'd2;
  localparam reg_addr_t REG_CAP_ADDR1 = 3'd3;
  localparam reg_addr_t REG_CAP_LANE  = 3'd4;
  localparam reg_addr_t REG_CAP_DATA0 = 3'd5;  // RO
  localparam reg_addr_t REG_CAP_DATA1 = 3'd6;  // RO
  localparam reg_addr_t REG_SM_COUNT  = 3'd7;  // Any write clears

  ////////////////////
  // Sticky flag positions
  ////////////////////
  localparam int NUM_FLAGS      = 9;
  localparam int FLAG_AGGR_RDY  = 0;
  localparam int FLAG_AGGR_VLD  = 1;
  localparam int FLAG_SM_RDY    = 2;
  localparam int FLAG_SM_VLD    = 3;
  localparam int FLAG_DMVM_RDY  = 4;
  localparam int FLAG_DMVM_VLD  = 5;
  localparam int FLAG_SPMM_RDY  = 6;
  localparam int FLAG_SPMM_VLD  = 7;
  localparam int FLAG_FEAT_HIGH = 8;

  typedef logic [NUM_FLAGS-1:0] flags_t;

  // ID register is the tag over the sparse item count
  localparam logic [23:0] DBG_ID_TAG   = 24'hA7D0B6;
  localparam reg_data_t   DBG_ID_VALUE = {DBG_ID_TAG, 8'(gat_pkg::GAT_NUM_SPARSE)};

  typedef enum logic [1:0] {
    IDLE,
    ACK,
    WAIT_DROP
  } acc_state_e;

endpackage

// File: hdl/dbg_if.sv
`timescale 1ns/1ps

interface dbg_if;

  // Configuration, owned by the register block
  gat_pkg::wh_addr_t  cap_addr0;
  gat_pkg::wh_addr_t  cap_addr1;
  gat_pkg::lane_sel_t cap_lane;
  dbg_pkg::flags_t    sticky_clr;  // One-cycle mask
  logic               cnt_clr;     // One-cycle pulse

  // Status back from the monitors
  dbg_pkg::flags_t    flags;
  dbg_pkg::reg_data_t cap_data0;
  dbg_pkg::reg_data_t cap_data1;
  dbg_pkg::reg_data_t sm_count;

  modport regs (
    output cap_addr0, cap_addr1, cap_lane, sticky_clr, cnt_clr,
    input  flags, cap_data0, cap_data1, sm_count
  );

  modport sticky (
    input  sticky_clr,
    output flags
  );

  modport capture (
    input  cap_addr0, cap_addr1, cap_lane, cnt_clr,
    output cap_data0, cap_data1, sm_count
  );

endinterface

// File: hdl/dbg_regs.sv
`timescale 1ns/1ps

module dbg_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               host_req_i,
  input  logic               host_we_i,
  input  dbg_pkg::reg_addr_t host_addr_i,
  input  dbg_pkg::reg_data_t host_wdata_i,
  output logic               host_ack_o,
  output dbg_pkg::reg_data_t host_rdata_o,
  dbg_if.regs                cfg
);

  dbg_pkg::acc_state_e state;
  dbg_pkg::reg_addr_t  acc_addr;
  logic                acc_we;
  dbg_pkg::reg_data_t  acc_wdata;
  dbg_pkg::reg_data_t  rd_mux;
  logic                do_wr;

  ////////////////////
  // Access capture
  ////////////////////
  always_ff @(posedge clk) begin
    if (state == dbg_pkg::IDLE && host_req_i) begin
      acc_addr  <= host_addr_i;
      acc_we    <= host_we_i;
      acc_wdata <= host_wdata_i;
    end
  end

  assign do_wr = (state == dbg_pkg::ACK) && acc_we;  // Lands on the ack edge

  ////////////////////
  // Four-phase handshake
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= dbg_pkg::IDLE;
      host_ack_o   <= 1'b0;
      host_rdata_o <= '0;
    end else begin
      case (state)
        dbg_pkg::IDLE: begin
          if (host_req_i) state <= dbg_pkg::ACK;
        end
        dbg_pkg::ACK: begin
          host_ack_o   <= 1'b1;
          host_rdata_o <= rd_mux;
          state        <= dbg_pkg::WAIT_DROP;
        end
        dbg_pkg::WAIT_DROP: begin
          if (!host_req_i) begin
            host_ack_o <= 1'b0;
            state      <= dbg_pkg::IDLE;
          end
        end
        default: state <= dbg_pkg::IDLE;
      endcase
    end
  end

  ////////////////////
  // Configuration
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg.cap_addr0 <= '0;
      cfg.cap_addr1 <= '0;
      cfg.cap_lane  <= '0;
    end else if (do_wr) begin
      case (acc_addr)
        dbg_pkg::REG_CAP_ADDR0: cfg.cap_addr0 <= acc_wdata[gat_pkg::GAT_WH_ADDR_W-1:0];
        dbg_pkg::REG_CAP_ADDR1: cfg.cap_addr1 <= acc_wdata[gat_pkg::GAT_WH_ADDR_W-1:0];
        dbg_pkg::REG_CAP_LANE:  cfg.cap_lane  <= acc_wdata[gat_pkg::GAT_LANE_SEL_W-1:0];
        default: ;  // RO and clear-only indices
      endcase
    end
  end

  assign cfg.sticky_clr = (do_wr && acc_addr == dbg_pkg::REG_STICKY) ?
                          acc_wdata[dbg_pkg::NUM_FLAGS-1:0] : '0;
  assign cfg.cnt_clr    = do_wr && (acc_addr == dbg_pkg::REG_SM_COUNT);

  always_comb begin
    case (acc_addr)
      dbg_pkg::REG_ID:        rd_mux = dbg_pkg::DBG_ID_VALUE;
      dbg_pkg::REG_STICKY:    rd_mux = dbg_pkg::reg_data_t'(cfg.flags);
      dbg_pkg::REG_CAP_ADDR0: rd_mux = dbg_pkg::reg_data_t'(cfg.cap_addr0);
      dbg_pkg::REG_CAP_ADDR1: rd_mux = dbg_pkg::reg_data_t'(cfg.cap_addr1);
      dbg_pkg::REG_CAP_LANE:  rd_mux = dbg_pkg::reg_data_t'(cfg.cap_lane);
      dbg_pkg::REG_CAP_DATA0: rd_mux = cfg.cap_data0;
      dbg_pkg::REG_CAP_DATA1: rd_mux = cfg.cap_data1;
      dbg_pkg::REG_SM_COUNT:  rd_mux = cfg.sm_count;
      default:                rd_mux = '0;
    endcase
  end

  // Ack only ever answers a request that is being held
  a_ack_after_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(host_ack_o) |-> $past(host_req_i)
  );

endmodule

// File: hdl/dbg_sticky.sv
`timescale 1ns/1ps

module dbg_sticky (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                spmm_vld_i,
  input  logic                spmm_rdy_i,
  input  logic                dmvm_vld_i,
  input  logic                dmvm_rdy_i,
  input  logic                sm_vld_i,
  input  logic                sm_rdy_i,
  input  logic                aggr_vld_i,
  input  logic                aggr_rdy_i,
  input  logic                feat_bram_ena_i,
  input  gat_pkg::feat_addr_t feat_bram_addra_i,
  dbg_if.sticky               mon
);

  dbg_pkg::flags_t probe_vec;
  logic            feat_high_wr;

  assign feat_high_wr = feat_bram_ena_i && (feat_bram_addra_i >= gat_pkg::FEAT_HIGH_ADDR);

  ////////////////////
  // Probe vector
  ////////////////////
  always_comb begin
    probe_vec                          = '0;
    probe_vec[dbg_pkg::FLAG_AGGR_RDY]  = aggr_rdy_i;
    probe_vec[dbg_pkg::FLAG_AGGR_VLD]  = aggr_vld_i;
    probe_vec[dbg_pkg::FLAG_SM_RDY]    = sm_rdy_i;
    probe_vec[dbg_pkg::FLAG_SM_VLD]    = sm_vld_i;
    probe_vec[dbg_pkg::FLAG_DMVM_RDY]  = dmvm_rdy_i;
    probe_vec[dbg_pkg::FLAG_DMVM_VLD]  = dmvm_vld_i;
    probe_vec[dbg_pkg::FLAG_SPMM_RDY]  = spmm_rdy_i;
    probe_vec[dbg_pkg::FLAG_SPMM_VLD]  = spmm_vld_i;
    probe_vec[dbg_pkg::FLAG_FEAT_HIGH] = feat_high_wr;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mon.flags <= '0;
    end else begin
      mon.flags <= (mon.flags & ~mon.sticky_clr) | probe_vec;  // Set beats clear
    end
  end

  // A sampled probe must show in the flags even when the host clears it
  a_probe_sets_flag: assert property (
    @(posedge clk) disable iff (!rst_n)
    (probe_vec != '0) |=> ((mon.flags & $past(probe_vec)) == $past(probe_vec))
  );

endmodule

// File: hdl/dbg_capture.sv
`timescale 1ns/1ps

module dbg_capture (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               spmm_rdy_i,
  input  logic               sm_vld_i,
  input  gat_pkg::wh_addr_t  wh_bram_addra_i,
  input  gat_pkg::sppe_bus_t sppe_i,
  dbg_if.capture             mon
);

  gat_pkg::lane_t lane_val;
  logic           hit0;
  logic           hit1;

  assign lane_val = sppe_i[mon.cap_lane];

  // Capture only while spmm accepts data
  assign hit0 = spmm_rdy_i && (wh_bram_addra_i == mon.cap_addr0);
  assign hit1 = spmm_rdy_i && (wh_bram_addra_i == mon.cap_addr1);

  ////////////////////
  // Lane capture slots
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mon.cap_data0 <= '0;
      mon.cap_data1 <= '0;
    end else begin
      if (hit0) mon.cap_data0 <= dbg_pkg::reg_data_t'(lane_val);
      if (hit1) mon.cap_data1 <= dbg_pkg::reg_data_t'(lane_val);
    end
  end

  ////////////////////
  // Softmax activity
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mon.sm_count <= '0;
    end else if (mon.cnt_clr) begin
      mon.sm_count <= '0;  // Drops a same-cycle increment
    end else if (sm_vld_i) begin
      mon.sm_count <= mon.sm_count + 1'b1;
    end
  end

  // Lane select written by the host must address an existing lane
  a_lane_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    $unsigned(mon.cap_lane) < gat_pkg::GAT_NUM_LANES
  );

endmodule

// File: hdl/gat_debug_top.sv
`timescale 1ns/1ps

module gat_debug_top (
  input  logic                clk,
  input  logic                rst_n,

  // Stage handshakes
  input  logic                spmm_vld_i,
  input  logic                spmm_rdy_i,
  input  logic                dmvm_vld_i,
  input  logic                dmvm_rdy_i,
  input  logic                sm_vld_i,
  input  logic                sm_rdy_i,
  input  logic                aggr_vld_i,
  input  logic                aggr_rdy_i,

  // Memory probes
  input  gat_pkg::sppe_bus_t  sppe_i,
  input  gat_pkg::wh_addr_t   wh_bram_addra_i,
  input  logic                feat_bram_ena_i,
  input  gat_pkg::feat_addr_t feat_bram_addra_i,

  // Host access
  input  logic                host_req_i,
  input  logic                host_we_i,
  input  dbg_pkg::reg_addr_t  host_addr_i,
  input  dbg_pkg::reg_data_t  host_wdata_i,
  output logic                host_ack_o,
  output dbg_pkg::reg_data_t  host_rdata_o
);

  dbg_if u_dbg_if ();

  dbg_regs u_dbg_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_ack_o   (host_ack_o),
    .host_rdata_o (host_rdata_o),
    .cfg          (u_dbg_if.regs)
  );

  dbg_sticky u_dbg_sticky (
    .clk               (clk),
    .rst_n             (rst_n),
    .spmm_vld_i        (spmm_vld_i),
    .spmm_rdy_i        (spmm_rdy_i),
    .dmvm_vld_i        (dmvm_vld_i),
    .dmvm_rdy_i        (dmvm_rdy_i),
    .sm_vld_i          (sm_vld_i),
    .sm_rdy_i          (sm_rdy_i),
    .aggr_vld_i        (aggr_vld_i),
    .aggr_rdy_i        (aggr_rdy_i),
    .feat_bram_ena_i   (feat_bram_ena_i),
    .feat_bram_addra_i (feat_bram_addra_i),
    .mon               (u_dbg_if.sticky)
  );

  dbg_capture u_dbg_capture (
    .clk             (clk),
    .rst_n           (rst_n),
    .spmm_rdy_i      (spmm_rdy_i),
    .sm_vld_i        (sm_vld_i),
    .wh_bram_addra_i (wh_bram_addra_i),
    .sppe_i          (sppe_i),
    .mon             (u_dbg_if.capture)
  );

endmodule

// File: verif/tb_gat_debug.sv
`timescale 1ns/1ps

module tb_gat_debug;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int ACK_TIMEOUT = 20;  // Edges

  localparam int OP_PULSE = 0;  // One-cycle pulse on probe bit arg
  localparam int OP_FEAT  = 1;
  localparam int OP_CAP   = 2;
  localparam int OP_SMVLD = 3;
  localparam int OP_WRITE = 4;
  localparam int OP_READ  = 5;
  localparam int OP_HOLD  = 6;  // Steady probe level
  localparam int OP_WREL  = 7;  // Write, held probes drop once ack rises

  localparam logic [31:0] EXP_PRED = 32'hFFFF_FFFF;  // Take the lane model
  localparam logic [31:0] ID_EXP   = {dbg_pkg::DBG_ID_TAG, 8'd12};

  logic                clk;
  logic                rst_n;
  logic [7:0]          probe;  // Bit k drives the input behind flag k
  logic [7:0]          probe_level;
  gat_pkg::sppe_bus_t  sppe;
  gat_pkg::wh_addr_t   wh_addr;
  logic                feat_ena;
  gat_pkg::feat_addr_t feat_addr;
  logic                host_req;
  logic                host_we;
  dbg_pkg::reg_addr_t  host_addr;
  dbg_pkg::reg_data_t  host_wdata;
  logic                host_ack;
  dbg_pkg::reg_data_t  host_rdata;

  // Prediction state
  logic [31:0]         lcg_state;
  logic [11:0]         lane_copy [16];
  gat_pkg::wh_addr_t   m_cap_addr0;
  gat_pkg::wh_addr_t   m_cap_addr1;
  logic [3:0]          m_cap_lane;
  logic [31:0]         pred_cap0;
  logic [31:0]         pred_cap1;

  int                  step_op[$];
  logic [31:0]         step_arg[$];
  logic [31:0]         step_data[$];
  logic [31:0]         step_exp[$];
  string               step_name[$];

  gat_debug_top u_gat_debug_top (
    .clk (clk), .rst_n (rst_n),
    .spmm_vld_i (probe[7]), .spmm_rdy_i (probe[6]),
    .dmvm_vld_i (probe[5]), .dmvm_rdy_i (probe[4]),
    .sm_vld_i (probe[3]), .sm_rdy_i (probe[2]),
    .aggr_vld_i (probe[1]), .aggr_rdy_i (probe[0]),
    .sppe_i (sppe), .wh_bram_addra_i (wh_addr),
    .feat_bram_ena_i (feat_ena), .feat_bram_addra_i (feat_addr),
    .host_req_i (host_req), .host_we_i (host_we),
    .host_addr_i (host_addr), .host_wdata_i (host_wdata),
    .host_ack_o (host_ack), .host_rdata_o (host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      report_fail($sformatf("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic step_clk();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic fill_lanes();
    logic [31:0] r;
    for (int i = 0; i < 16; i++) begin
      r            = lcg_next();
      lane_copy[i] = r[27:16];  // Upper bits, less periodic
      sppe[i]      = r[27:16];
    end
  endtask

  // Slot loads when the driven address matches its configured address
  task automatic predict_capture();
    if (wh_addr == m_cap_addr0) pred_cap0 = {20'd0, lane_copy[m_cap_lane]};
    if (wh_addr == m_cap_addr1) pred_cap1 = {20'd0, lane_copy[m_cap_lane]};
  endtask

  task automatic host_access(input string name, input logic we, input dbg_pkg::reg_addr_t addr,
                             input logic [31:0] wdata, input logic drop_hold,
                             output logic [31:0] rdata);
    int waited;
    if (host_ack !== 1'b0) report_fail($sformatf("%s: ack high before the request", name));
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    host_req   = 1'b1;
    waited     = 0;
    while (host_ack !== 1'b1) begin
      step_clk();
      waited++;
      if (waited > ACK_TIMEOUT) report_fail($sformatf("%s: ack never rose", name));
    end
    check_value($sformatf("%s ack rise", name), 32'd2, waited);
    rdata    = host_rdata;
    if (drop_hold) begin
      probe_level = '0;  // Probe seen only on the write edge
      probe       = probe_level;
    end
    host_req = 1'b0;
    waited   = 0;
    while (host_ack !== 1'b0) begin
      step_clk();
      waited++;
      if (waited > ACK_TIMEOUT) report_fail($sformatf("%s: ack never fell", name));
    end
    check_value($sformatf("%s ack fall", name), 32'd1, waited);
    host_we = 1'b0;
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////
  task automatic add_step(input int op, input int arg, input logic [31:0] data,
                          input logic [31:0] exp, input string name);
    step_op.push_back(op);
    step_arg.push_back(arg);
    step_data.push_back(data);
    step_exp.push_back(exp);
    step_name.push_back(name);
  endtask

  task automatic add_reg(input int op, input dbg_pkg::reg_addr_t addr, input logic [31:0] data,
                         input logic [31:0] exp, input string name);
    add_step(op, int'({29'd0, addr}), data, exp, name);
  endtask

  task automatic build_table();
    add_reg(OP_READ, dbg_pkg::REG_ID, 0, ID_EXP, "id after reset");
    add_reg(OP_READ, dbg_pkg::REG_STICKY, 0, 0, "sticky after reset");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA0, 0, 0, "cap0 after reset");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA1, 0, 0, "cap1 after reset");
    add_reg(OP_READ, dbg_pkg::REG_SM_COUNT, 0, 0, "count after reset");
    add_reg(OP_READ, dbg_pkg::REG_CAP_LANE, 0, 0, "lane after reset");
    for (int k = 0; k < 8; k++) begin
      add_step(OP_PULSE, k, 0, 0, $sformatf("pulse probe %0d", k));
      add_reg(OP_READ, dbg_pkg::REG_STICKY, 0, (32'd1 << (k + 1)) - 32'd1,
              $sformatf("sticky accumulate %0d", k));
    end
    add_reg(OP_WRITE, dbg_pkg::REG_STICKY, 32'h0A5, 0, "sticky clear mask");
    add_reg(OP_READ, dbg_pkg::REG_STICKY, 0, 32'h05A, "sticky after mask");
    add_step(OP_HOLD, 0, 32'h02, 0, "hold aggr_vld");
    add_reg(OP_WREL, dbg_pkg::REG_STICKY, 32'h1FF, 0, "clear under hold");
    add_reg(OP_READ, dbg_pkg::REG_STICKY, 0, 32'h002, "set beats clear");
    add_reg(OP_WRITE, dbg_pkg::REG_STICKY, 32'h002, 0, "clear aggr_vld");
    add_step(OP_FEAT, 43327, 1, 0, "feat write below");
    add_step(OP_FEAT, 43328, 0, 0, "feat high disabled");
    add_reg(OP_READ, dbg_pkg::REG_STICKY, 0, 0, "feat high still clear");
    add_step(OP_FEAT, 43328, 1, 0, "feat high write");
    add_reg(OP_READ, dbg_pkg::REG_STICKY, 0, 32'h100, "feat high flag");
    add_reg(OP_READ, dbg_pkg::REG_SM_COUNT, 0, 1, "count from pulse");
    add_reg(OP_WRITE, dbg_pkg::REG_SM_COUNT, 0, 0, "count clear");
    add_step(OP_SMVLD, 5, 0, 0, "sm_vld 5 cycles");
    add_reg(OP_READ, dbg_pkg::REG_SM_COUNT, 0, 5, "count 5");
    add_step(OP_SMVLD, 7, 0, 0, "sm_vld 7 cycles");
    add_reg(OP_READ, dbg_pkg::REG_SM_COUNT, 0, 12, "count 12");
    add_reg(OP_WRITE, dbg_pkg::REG_SM_COUNT, 32'hDEAD, 0, "count clear any data");
    add_reg(OP_READ, dbg_pkg::REG_SM_COUNT, 0, 0, "count cleared");
    add_reg(OP_WRITE, dbg_pkg::REG_CAP_ADDR0, 32'h8000_0123, 0, "cfg addr0");
    add_reg(OP_WRITE, dbg_pkg::REG_CAP_ADDR1, 32'h2A5C, 0, "cfg addr1");
    add_reg(OP_WRITE, dbg_pkg::REG_CAP_LANE, 5, 0, "cfg lane");
    add_reg(OP_READ, dbg_pkg::REG_CAP_ADDR0, 0, 32'h0123, "addr0 readback");
    add_reg(OP_READ, dbg_pkg::REG_CAP_ADDR1, 0, 32'h2A5C, "addr1 readback");
    add_reg(OP_READ, dbg_pkg::REG_CAP_LANE, 0, 5, "lane readback");
    add_step(OP_CAP, 32'h0123, 1, 0, "hit slot0");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA0, 0, EXP_PRED, "slot0 loaded");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA1, 0, EXP_PRED, "slot1 untouched");
    add_step(OP_CAP, 32'h2A5C, 1, 0, "hit slot1");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA1, 0, EXP_PRED, "slot1 loaded");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA0, 0, EXP_PRED, "slot0 kept");
    add_step(OP_CAP, 32'h0123, 0, 0, "match without rdy");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA0, 0, EXP_PRED, "slot0 no rdy");
    add_step(OP_CAP, 32'h0124, 1, 0, "rdy without match");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA0, 0, EXP_PRED, "slot0 no match");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA1, 0, EXP_PRED, "slot1 no match");
    add_reg(OP_WRITE, dbg_pkg::REG_CAP_LANE, 11, 0, "cfg lane 11");
    add_step(OP_CAP, 32'h2A5C, 1, 0, "hit slot1 lane 11");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA1, 0, EXP_PRED, "slot1 lane 11");
    add_reg(OP_WRITE, dbg_pkg::REG_ID, 32'hFFFF_FFFF, 0, "write id");
    add_reg(OP_READ, dbg_pkg::REG_ID, 0, ID_EXP, "id read only");
    add_reg(OP_WRITE, dbg_pkg::REG_CAP_DATA0, 0, 0, "write cap0");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA0, 0, EXP_PRED, "cap0 read only");
    add_reg(OP_WRITE, dbg_pkg::REG_CAP_DATA1, 32'h5555, 0, "write cap1");
    add_reg(OP_READ, dbg_pkg::REG_CAP_DATA1, 0, EXP_PRED, "cap1 read only");
  endtask

  task automatic run_step(input int idx);
    logic [31:0] arg;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] rdata;
    string       name;
    arg  = step_arg[idx];
    data = step_data[idx];
    exp  = step_exp[idx];
    name = step_name[idx];
    case (step_op[idx])
      OP_PULSE: begin
        probe = probe_level | (8'd1 << arg[2:0]);
        if (probe[6]) predict_capture();  // spmm_rdy also arms capture
        step_clk();
        probe = probe_level;
      end
      OP_FEAT: begin
        feat_addr = arg[15:0];
        feat_ena  = data[0];
        step_clk();
        feat_ena  = 1'b0;
      end
      OP_CAP: begin
        fill_lanes();
        wh_addr  = arg[13:0];
        probe[6] = data[0];
        if (data[0]) predict_capture();
        step_clk();
        probe    = probe_level;
      end
      OP_SMVLD: begin
        probe[3] = 1'b1;
        repeat (arg) step_clk();
        probe    = probe_level;
      end
      OP_WRITE, OP_WREL: begin
        host_access(name, 1'b1, arg[2:0], data, step_op[idx] == OP_WREL, rdata);
        case (arg[2:0])
          dbg_pkg::REG_CAP_ADDR0: m_cap_addr0 = data[13:0];
          dbg_pkg::REG_CAP_ADDR1: m_cap_addr1 = data[13:0];
          dbg_pkg::REG_CAP_LANE:  m_cap_lane  = data[3:0];
          default: ;
        endcase
      end
      OP_READ: begin
        host_access(name, 1'b0, arg[2:0], 32'd0, 1'b0, rdata);
        if (exp == EXP_PRED) exp = (arg[2:0] == dbg_pkg::REG_CAP_DATA0) ? pred_cap0 : pred_cap1;
        check_value(name, exp, rdata);
      end
      OP_HOLD: begin
        probe_level = data[7:0];
        probe       = probe_level;
        step_clk();
      end
      default: report_fail($sformatf("%s: unknown step operation", name));
    endcase
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    lcg_state   = 32'd81;
    rst_n       = 1'b0;
    probe       = '0;
    probe_level = '0;
    sppe        = '0;
    wh_addr     = '0;
    feat_ena    = 1'b0;
    feat_addr   = '0;
    host_req    = 1'b0;
    host_we     = 1'b0;
    host_addr   = '0;
    host_wdata  = '0;
    m_cap_addr0 = '0;
    m_cap_addr1 = '0;
    m_cap_lane  = '0;
    pred_cap0   = '0;
    pred_cap1   = '0;
    for (int i = 0; i < 16; i++) lane_copy[i] = '0;
    build_table();
    repeat (8) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    step_clk();
    check_value("ack after reset", 32'd0, {31'd0, host_ack});
    for (int i = 0; i < step_op.size(); i++) run_step(i);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: list.f
hdl/gat_pkg.sv
hdl/dbg_pkg.sv
hdl/dbg_if.sv
hdl/dbg_regs.sv
hdl/dbg_sticky.sv
hdl/dbg_capture.sv
hdl/gat_debug_top.sv
verif/tb_gat_debug.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_gat_debug
FILELIST   := list.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
